// File: rtl/exu_settings.svh
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// datapath widths fixed by RV32E
`define EXU_XLEN 32
`define EXU_CSR_AW 12
`define EXU_REG_AW 4

// data RAM depth in words
`define EXU_RAM_WORDS 256

// machine CSR addresses
`define EXU_CSR_MSTATUS 12'h300
`define EXU_CSR_MTVEC 12'h305
`define EXU_CSR_MEPC 12'h341
`define EXU_CSR_MCAUSE 12'h342

`endif

// File: rtl/exu_isa_pkg.sv
`default_nettype none

`include "exu_settings.svh"

package exu_isa_pkg;

  typedef logic [`EXU_XLEN-1:0] word_t;
  typedef logic [`EXU_REG_AW-1:0] reg_idx_t;
  typedef logic [`EXU_CSR_AW-1:0] csr_addr_t;

  // alu operation codes
  typedef logic [3:0] alu_op_t;
  localparam alu_op_t ALU_ADD = 4'd0;
  localparam alu_op_t ALU_SUB = 4'd1;
  localparam alu_op_t ALU_SLL = 4'd2;
  localparam alu_op_t ALU_SLT = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_SLE = 4'd5;
  localparam alu_op_t ALU_SLEU = 4'd6;
  localparam alu_op_t ALU_XOR = 4'd7;
  localparam alu_op_t ALU_SRL = 4'd8;
  localparam alu_op_t ALU_SRA = 4'd9;
  localparam alu_op_t ALU_OR = 4'd10;
  localparam alu_op_t ALU_AND = 4'd11;

  // instruction class from the decoder
  typedef logic [2:0] op_class_t;
  localparam op_class_t OP_ALU = 3'd0;
  localparam op_class_t OP_BRANCH = 3'd1;
  localparam op_class_t OP_JUMP = 3'd2;
  localparam op_class_t OP_LOAD = 3'd3;
  localparam op_class_t OP_STORE = 3'd4;
  localparam op_class_t OP_CSR = 3'd5;
  localparam op_class_t OP_ECALL = 3'd6;
  localparam op_class_t OP_MRET = 3'd7;

  // zicsr function, immediate forms come in through src1
  typedef logic [1:0] csr_func_t;
  localparam csr_func_t CSR_WRITE = 2'd0;
  localparam csr_func_t CSR_SET = 2'd1;
  localparam csr_func_t CSR_CLEAR = 2'd2;

endpackage

`default_nettype wire

// File: rtl/exu_bus_pkg.sv
`default_nettype none

`include "exu_settings.svh"

package exu_bus_pkg;

  // word address into the data RAM
  typedef logic [$clog2(`EXU_RAM_WORDS)-1:0] wb_addr_t;

  // wishbone master sequencing
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUS = 2'd1,
    DONE = 2'd2
  } lsu_state_t;

endpackage

`default_nettype wire

// File: rtl/exu_alu.sv
`timescale 1ns/1ns
`default_nettype none

module exu_alu (
  input  exu_isa_pkg::word_t   src1_i,
  input  exu_isa_pkg::word_t   src2_i,
  input  exu_isa_pkg::alu_op_t alu_op_i,
  output exu_isa_pkg::word_t   res_o
);

  logic [4:0] shamt;

  assign shamt = src2_i[4:0];

  always_comb begin
    case (alu_op_i)
      exu_isa_pkg::ALU_ADD: res_o = src1_i + src2_i;
      exu_isa_pkg::ALU_SUB: res_o = src1_i - src2_i;
      exu_isa_pkg::ALU_SLL: res_o = src1_i << shamt;
      exu_isa_pkg::ALU_SLT: res_o = {31'd0, $signed(src1_i) < $signed(src2_i)};
      exu_isa_pkg::ALU_SLTU: res_o = {31'd0, src1_i < src2_i};
      exu_isa_pkg::ALU_SLE: res_o = {31'd0, $signed(src1_i) <= $signed(src2_i)};
      exu_isa_pkg::ALU_SLEU: res_o = {31'd0, src1_i <= src2_i};
      exu_isa_pkg::ALU_XOR: res_o = src1_i ^ src2_i;
      exu_isa_pkg::ALU_SRL: res_o = src1_i >> shamt;
      exu_isa_pkg::ALU_SRA: res_o = $signed(src1_i) >>> shamt;
      exu_isa_pkg::ALU_OR: res_o = src1_i | src2_i;
      exu_isa_pkg::ALU_AND: res_o = src1_i & src2_i;
      default: res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/exu_csr.sv
`timescale 1ns/1ns
`default_nettype none

`include "exu_settings.svh"

module exu_csr (
  input  logic                   clk,
  input  logic                   rst,
  input  exu_isa_pkg::csr_addr_t raddr_i,
  input  logic                   commit_i,
  input  logic                   wen_i,
  input  exu_isa_pkg::word_t     wdata_i,
  input  logic                   ecall_i,
  input  logic                   mret_i,
  input  exu_isa_pkg::word_t     epc_i,
  output exu_isa_pkg::word_t     rdata_o,
  output exu_isa_pkg::word_t     mtvec_o,
  output exu_isa_pkg::word_t     mepc_o
);

  exu_isa_pkg::word_t mstatus_q;
  exu_isa_pkg::word_t mtvec_q;
  exu_isa_pkg::word_t mepc_q;
  exu_isa_pkg::word_t mcause_q;

  always_comb begin
    case (raddr_i)
      `EXU_CSR_MSTATUS: rdata_o = mstatus_q;
      `EXU_CSR_MTVEC: rdata_o = mtvec_q;
      `EXU_CSR_MEPC: rdata_o = mepc_q;
      `EXU_CSR_MCAUSE: rdata_o = mcause_q;
      default: rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q <= '0;
      mepc_q <= '0;
      mcause_q <= '0;
    end else if (commit_i) begin
      if (wen_i) begin
        case (raddr_i)
          `EXU_CSR_MSTATUS: mstatus_q <= wdata_i;
          `EXU_CSR_MTVEC: mtvec_q <= wdata_i;
          `EXU_CSR_MEPC: mepc_q <= wdata_i;
          `EXU_CSR_MCAUSE: mcause_q <= wdata_i;
          default: ;
        endcase
      end
      // environment call from M-mode
      if (ecall_i) begin
        mepc_q <= epc_i;
        mcause_q <= 32'd11;
      end
      // MPIE set, MIE restored from MPIE
      if (mret_i) begin
        mstatus_q <= {mstatus_q[31:8], 1'b1, mstatus_q[6:4], mstatus_q[7], mstatus_q[2:0]};
      end
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o = mepc_q;

  a_no_ecall_mret : assert property (@(posedge clk) disable iff (rst)
    commit_i |-> !(ecall_i && mret_i))
    else $error("ecall and mret committed together");

endmodule

`default_nettype wire

// File: rtl/exu_lsu_wb.sv
`timescale 1ns/1ns
`default_nettype none

module exu_lsu_wb (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_i,
  input  logic                  we_i,
  input  exu_bus_pkg::wb_addr_t addr_i,
  input  exu_isa_pkg::word_t    wdata_i,
  input  logic                  wb_ack_i,
  input  exu_isa_pkg::word_t    wb_dat_i,
  output logic                  done_o,
  output exu_isa_pkg::word_t    rdata_o,
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output exu_bus_pkg::wb_addr_t wb_adr_o,
  output exu_isa_pkg::word_t    wb_dat_o
);

  exu_bus_pkg::lsu_state_t state_q;
  logic we_q;
  exu_bus_pkg::wb_addr_t adr_q;
  exu_isa_pkg::word_t dat_q;
  exu_isa_pkg::word_t rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= exu_bus_pkg::IDLE;
    end else begin
      case (state_q)
        exu_bus_pkg::IDLE: if (req_i) state_q <= exu_bus_pkg::BUS;
        exu_bus_pkg::BUS: if (wb_ack_i) state_q <= exu_bus_pkg::DONE;
        default: state_q <= exu_bus_pkg::IDLE;
      endcase
    end
  end

  // request latched so the bus lines stay put until ack
  always_ff @(posedge clk) begin
    if (state_q == exu_bus_pkg::IDLE && req_i) begin
      we_q <= we_i;
      adr_q <= addr_i;
      dat_q <= wdata_i;
    end
    if (state_q == exu_bus_pkg::BUS && wb_ack_i && !we_q) begin
      rdata_q <= wb_dat_i;
    end
  end

  assign wb_cyc_o = (state_q == exu_bus_pkg::BUS);
  assign wb_stb_o = (state_q == exu_bus_pkg::BUS);
  assign wb_we_o = we_q;
  assign wb_adr_o = adr_q;
  assign wb_dat_o = dat_q;
  assign done_o = (state_q == exu_bus_pkg::DONE);
  assign rdata_o = rdata_q;

  a_ack_in_cycle : assert property (@(posedge clk) disable iff (rst)
    wb_ack_i |-> wb_cyc_o && wb_stb_o)
    else $error("ack outside a strobed bus cycle");

  a_bus_stable : assert property (@(posedge clk) disable iff (rst)
    wb_stb_o && !wb_ack_i |=> $stable(wb_adr_o) && $stable(wb_dat_o) && $stable(wb_we_o))
    else $error("bus lines changed before ack");

  a_req_idle : assert property (@(posedge clk) disable iff (rst)
    req_i |-> state_q == exu_bus_pkg::IDLE)
    else $error("request while a bus cycle is in flight");

endmodule

`default_nettype wire

// File: rtl/exu_stage.sv
`timescale 1ns/1ns
`default_nettype none

module exu_stage (
  input  logic                      clk,
  input  logic                      rst,
  // issue side
  input  logic                      prev_valid_i,
  input  exu_isa_pkg::op_class_t    op_class_i,
  input  exu_isa_pkg::alu_op_t      alu_op_i,
  input  exu_isa_pkg::csr_func_t    csr_func_i,
  input  exu_isa_pkg::word_t        src1_i,
  input  exu_isa_pkg::word_t        src2_i,
  input  exu_isa_pkg::word_t        base_i,
  input  exu_isa_pkg::word_t        imm_i,
  input  exu_isa_pkg::word_t        pc_i,
  input  exu_isa_pkg::reg_idx_t     rd_i,
  output logic                      ready_o,
  // result side
  output logic                      valid_o,
  output exu_isa_pkg::reg_idx_t     rd_o,
  output exu_isa_pkg::word_t        reg_wdata_o,
  output logic                      redirect_o,
  output exu_isa_pkg::word_t        npc_o,
  output exu_isa_pkg::word_t        pc_o,
  input  logic                      next_ready_i,
  // data bus
  output logic                      wb_cyc_o,
  output logic                      wb_stb_o,
  output logic                      wb_we_o,
  output exu_bus_pkg::wb_addr_t     wb_adr_o,
  output exu_isa_pkg::word_t        wb_dat_o,
  input  logic                      wb_ack_i,
  input  exu_isa_pkg::word_t        wb_dat_i
);

  logic accept;
  logic consume;
  logic is_mem_in;
  logic valid_q;
  logic mem_busy_q;
  logic req_q;

  exu_isa_pkg::op_class_t op_class_q;
  exu_isa_pkg::alu_op_t alu_op_q;
  exu_isa_pkg::csr_func_t csr_func_q;
  exu_isa_pkg::word_t src1_q;
  exu_isa_pkg::word_t src2_q;
  exu_isa_pkg::word_t base_q;
  exu_isa_pkg::word_t imm_q;
  exu_isa_pkg::word_t pc_q;
  exu_isa_pkg::reg_idx_t rd_q;

  exu_isa_pkg::word_t alu_res;
  exu_isa_pkg::word_t target;
  exu_isa_pkg::word_t csr_rdata;
  exu_isa_pkg::word_t csr_wdata;
  exu_isa_pkg::word_t mtvec;
  exu_isa_pkg::word_t mepc;
  exu_isa_pkg::word_t load_data;
  logic lsu_done;

  assign accept = prev_valid_i && ready_o;
  assign consume = valid_q && next_ready_i;
  assign is_mem_in = (op_class_i == exu_isa_pkg::OP_LOAD) ||
                     (op_class_i == exu_isa_pkg::OP_STORE);
  assign ready_o = !mem_busy_q && !(valid_q && !next_ready_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      mem_busy_q <= 1'b0;
      req_q <= 1'b0;
      op_class_q <= exu_isa_pkg::OP_ALU;
    end else begin
      req_q <= accept && is_mem_in;
      if (accept) begin
        op_class_q <= op_class_i;
        valid_q <= !is_mem_in;
        mem_busy_q <= is_mem_in;
      end else if (lsu_done) begin
        valid_q <= 1'b1;
        mem_busy_q <= 1'b0;
      end else if (consume) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      alu_op_q <= alu_op_i;
      csr_func_q <= csr_func_i;
      src1_q <= src1_i;
      src2_q <= src2_i;
      base_q <= base_i;
      imm_q <= imm_i;
      pc_q <= pc_i;
      rd_q <= rd_i;
    end
  end

  exu_alu u_alu (
    .src1_i  (src1_q),
    .src2_i  (src2_q),
    .alu_op_i(alu_op_q),
    .res_o   (alu_res)
  );

  // zicsr read-modify-write
  always_comb begin
    case (csr_func_q)
      exu_isa_pkg::CSR_WRITE: csr_wdata = src1_q;
      exu_isa_pkg::CSR_SET: csr_wdata = csr_rdata | src1_q;
      exu_isa_pkg::CSR_CLEAR: csr_wdata = csr_rdata & ~src1_q;
      default: csr_wdata = csr_rdata;
    endcase
  end

  // csr number travels in the low bits of imm
  exu_csr u_csr (
    .clk     (clk),
    .rst     (rst),
    .raddr_i (imm_q[11:0]),
    .commit_i(consume),
    .wen_i   (op_class_q == exu_isa_pkg::OP_CSR),
    .wdata_i (csr_wdata),
    .ecall_i (op_class_q == exu_isa_pkg::OP_ECALL),
    .mret_i  (op_class_q == exu_isa_pkg::OP_MRET),
    .epc_i   (pc_q),
    .rdata_o (csr_rdata),
    .mtvec_o (mtvec),
    .mepc_o  (mepc)
  );

  assign target = base_q + imm_q;

  exu_lsu_wb u_lsu (
    .clk     (clk),
    .rst     (rst),
    .req_i   (req_q),
    .we_i    (op_class_q == exu_isa_pkg::OP_STORE),
    .addr_i  (target[$bits(exu_bus_pkg::wb_addr_t)+1:2]),
    .wdata_i (src2_q),
    .wb_ack_i(wb_ack_i),
    .wb_dat_i(wb_dat_i),
    .done_o  (lsu_done),
    .rdata_o (load_data),
    .wb_cyc_o(wb_cyc_o),
    .wb_stb_o(wb_stb_o),
    .wb_we_o (wb_we_o),
    .wb_adr_o(wb_adr_o),
    .wb_dat_o(wb_dat_o)
  );

  always_comb begin
    case (op_class_q)
      exu_isa_pkg::OP_JUMP, exu_isa_pkg::OP_ECALL, exu_isa_pkg::OP_MRET: redirect_o = 1'b1;
      exu_isa_pkg::OP_BRANCH: begin
        case (alu_op_q)
          exu_isa_pkg::ALU_SUB: redirect_o = ~|alu_res;
          exu_isa_pkg::ALU_XOR, exu_isa_pkg::ALU_SLT, exu_isa_pkg::ALU_SLTU,
          exu_isa_pkg::ALU_SLE, exu_isa_pkg::ALU_SLEU: redirect_o = |alu_res;
          default: redirect_o = 1'b0;
        endcase
      end
      default: redirect_o = 1'b0;
    endcase
  end

  assign npc_o = (op_class_q == exu_isa_pkg::OP_ECALL) ? mtvec :
                 (op_class_q == exu_isa_pkg::OP_MRET) ? mepc : target;

  // x0 never gets a value
  assign reg_wdata_o = (rd_q == '0) ? '0 :
                       (op_class_q == exu_isa_pkg::OP_LOAD) ? load_data :
                       (op_class_q == exu_isa_pkg::OP_CSR) ? csr_rdata : alu_res;

  assign valid_o = valid_q;
  assign rd_o = rd_q;
  assign pc_o = pc_q;

  a_hold_stall : assert property (@(posedge clk) disable iff (rst)
    valid_o && !next_ready_i |=> valid_o && $stable(rd_o) && $stable(reg_wdata_o) &&
      $stable(redirect_o) && $stable(npc_o) && $stable(pc_o))
    else $error("result changed under back-pressure");

endmodule

`default_nettype wire

// File: rtl/data_ram_wb.sv
`timescale 1ns/1ns
`default_nettype none

`include "exu_settings.svh"

module data_ram_wb (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  exu_bus_pkg::wb_addr_t wb_adr_i,
  input  exu_isa_pkg::word_t    wb_dat_i,
  output logic                  wb_ack_o,
  output exu_isa_pkg::word_t    wb_dat_o
);

  exu_isa_pkg::word_t mem [`EXU_RAM_WORDS];
  exu_isa_pkg::word_t dat_q;
  logic ack_q;
  logic hit;

  // new strobe seen, ack is still low
  assign hit = wb_cyc_i && wb_stb_i && !ack_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= hit;
    end
  end

  always_ff @(posedge clk) begin
    if (hit) begin
      if (wb_we_i) begin
        mem[wb_adr_i] <= wb_dat_i;
      end
      dat_q <= mem[wb_adr_i];
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;

endmodule

`default_nettype wire

// File: rtl/exu_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

module exu_subsys_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   prev_valid_i,
  input  exu_isa_pkg::op_class_t op_class_i,
  input  exu_isa_pkg::alu_op_t   alu_op_i,
  input  exu_isa_pkg::csr_func_t csr_func_i,
  input  exu_isa_pkg::word_t     src1_i,
  input  exu_isa_pkg::word_t     src2_i,
  input  exu_isa_pkg::word_t     base_i,
  input  exu_isa_pkg::word_t     imm_i,
  input  exu_isa_pkg::word_t     pc_i,
  input  exu_isa_pkg::reg_idx_t  rd_i,
  output logic                   ready_o,
  output logic                   valid_o,
  output exu_isa_pkg::reg_idx_t  rd_o,
  output exu_isa_pkg::word_t     reg_wdata_o,
  output logic                   redirect_o,
  output exu_isa_pkg::word_t     npc_o,
  output exu_isa_pkg::word_t     pc_o,
  input  logic                   next_ready_i
);

  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic wb_ack;
  exu_bus_pkg::wb_addr_t wb_adr;
  exu_isa_pkg::word_t wb_dat_w;
  exu_isa_pkg::word_t wb_dat_r;

  exu_stage u_stage (
    .clk         (clk),
    .rst         (rst),
    .prev_valid_i(prev_valid_i),
    .op_class_i  (op_class_i),
    .alu_op_i    (alu_op_i),
    .csr_func_i  (csr_func_i),
    .src1_i      (src1_i),
    .src2_i      (src2_i),
    .base_i      (base_i),
    .imm_i       (imm_i),
    .pc_i        (pc_i),
    .rd_i        (rd_i),
    .ready_o     (ready_o),
    .valid_o     (valid_o),
    .rd_o        (rd_o),
    .reg_wdata_o (reg_wdata_o),
    .redirect_o  (redirect_o),
    .npc_o       (npc_o),
    .pc_o        (pc_o),
    .next_ready_i(next_ready_i),
    .wb_cyc_o    (wb_cyc),
    .wb_stb_o    (wb_stb),
    .wb_we_o     (wb_we),
    .wb_adr_o    (wb_adr),
    .wb_dat_o    (wb_dat_w),
    .wb_ack_i    (wb_ack),
    .wb_dat_i    (wb_dat_r)
  );

  data_ram_wb u_ram (
    .clk     (clk),
    .rst     (rst),
    .wb_cyc_i(wb_cyc),
    .wb_stb_i(wb_stb),
    .wb_we_i (wb_we),
    .wb_adr_i(wb_adr),
    .wb_dat_i(wb_dat_w),
    .wb_ack_o(wb_ack),
    .wb_dat_o(wb_dat_r)
  );

endmodule

`default_nettype wire

// File: testbench/exu_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "exu_settings.svh"

module exu_tb;

  typedef struct packed {
    exu_isa_pkg::reg_idx_t rd;
    exu_isa_pkg::word_t wdata;
    logic redirect;
    exu_isa_pkg::word_t npc;
    exu_isa_pkg::word_t pc;
  } exp_t;

  logic clk;
  logic rst;
  logic prev_valid_i;
  exu_isa_pkg::op_class_t op_class_i;
  exu_isa_pkg::alu_op_t alu_op_i;
  exu_isa_pkg::csr_func_t csr_func_i;
  exu_isa_pkg::word_t src1_i;
  exu_isa_pkg::word_t src2_i;
  exu_isa_pkg::word_t base_i;
  exu_isa_pkg::word_t imm_i;
  exu_isa_pkg::word_t pc_i;
  exu_isa_pkg::reg_idx_t rd_i;
  logic ready_o;
  logic valid_o;
  exu_isa_pkg::reg_idx_t rd_o;
  exu_isa_pkg::word_t reg_wdata_o;
  logic redirect_o;
  exu_isa_pkg::word_t npc_o;
  exu_isa_pkg::word_t pc_o;
  logic next_ready_i;

  // expected results in issue order
  exp_t exp_q[$];
  exp_t head;
  logic head_valid;

  exu_isa_pkg::word_t mem_model [`EXU_RAM_WORDS];
  exu_bus_pkg::wb_addr_t written_q[$];
  exu_isa_pkg::word_t m_mstatus;
  exu_isa_pkg::word_t m_mtvec;
  exu_isa_pkg::word_t m_mepc;
  exu_isa_pkg::word_t m_mcause;

  int errors;
  int results;
  int tests_run;
  int tests_failed;
  logic stall_en;
  int stretch;

  exu_subsys_top DUT (
    .clk         (clk),
    .rst         (rst),
    .prev_valid_i(prev_valid_i),
    .op_class_i  (op_class_i),
    .alu_op_i    (alu_op_i),
    .csr_func_i  (csr_func_i),
    .src1_i      (src1_i),
    .src2_i      (src2_i),
    .base_i      (base_i),
    .imm_i       (imm_i),
    .pc_i        (pc_i),
    .rd_i        (rd_i),
    .ready_o     (ready_o),
    .valid_o     (valid_o),
    .rd_o        (rd_o),
    .reg_wdata_o (reg_wdata_o),
    .redirect_o  (redirect_o),
    .npc_o       (npc_o),
    .pc_o        (pc_o),
    .next_ready_i(next_ready_i)
  );

  always #20 clk = ~clk;

  // back-pressure in random stretches
  always begin
    @(posedge clk);
    #2;
    if (!stall_en) begin
      next_ready_i = 1'b1;
    end else if (stretch == 0) begin
      next_ready_i = ($urandom % 2) == 0;
      stretch = 1 + int'($urandom % 5);
    end else begin
      stretch--;
    end
  end

  // head is taken mid-cycle while outputs are settled
  always @(negedge clk) begin
    head_valid <= valid_o && (exp_q.size() > 0);
    if (exp_q.size() > 0) begin
      head <= exp_q[0];
    end
  end

  always @(posedge clk) begin
    if (!rst && valid_o && next_ready_i) begin
      results++;
      if (exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
    end
  end

  task automatic report_mismatch();
    errors++;
    if (!head_valid) begin
      $display("FAIL %0t ns: result for pc %h arrived with none expected", $time, pc_o);
    end else begin
      $display("FAIL %0t ns: pc %h rd %0d data %h redir %b npc %h", $time,
               pc_o, rd_o, reg_wdata_o, redirect_o, npc_o);
      $display("  expected pc %h rd %0d data %h redir %b npc %h",
               head.pc, head.rd, head.wdata, head.redirect, head.npc);
    end
  endtask

  task automatic report_reset();
    errors++;
    $display("FAIL %0t ns: valid_o or ready_o wrong right after reset", $time);
  endtask

  a_result : assert property (@(posedge clk) disable iff (rst)
    valid_o && next_ready_i |-> head_valid && rd_o == head.rd &&
      reg_wdata_o == head.wdata && redirect_o == head.redirect &&
      npc_o == head.npc && pc_o == head.pc)
    else report_mismatch();

  a_reset_idle : assert property (@(posedge clk)
    rst |=> !valid_o && ready_o)
    else report_reset();

  task automatic timeout_abort(input string what);
    $display("timeout: %s", what);
    $display("FAIL: see errors above");
    $finish;
  endtask

  function automatic exu_isa_pkg::word_t alu_model(input exu_isa_pkg::alu_op_t op,
                                                   input exu_isa_pkg::word_t a,
                                                   input exu_isa_pkg::word_t b);
    case (op)
      exu_isa_pkg::ALU_ADD: return a + b;
      exu_isa_pkg::ALU_SUB: return a - b;
      exu_isa_pkg::ALU_SLL: return a << b[4:0];
      exu_isa_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      exu_isa_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      exu_isa_pkg::ALU_SLE: return ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
      exu_isa_pkg::ALU_SLEU: return (a <= b) ? 32'd1 : 32'd0;
      exu_isa_pkg::ALU_XOR: return a ^ b;
      exu_isa_pkg::ALU_SRL: return a >> b[4:0];
      exu_isa_pkg::ALU_SRA: return exu_isa_pkg::word_t'($signed(a) >>> b[4:0]);
      exu_isa_pkg::ALU_OR: return a | b;
      exu_isa_pkg::ALU_AND: return a & b;
      default: return '0;
    endcase
  endfunction

  function automatic exu_isa_pkg::word_t csr_read(input exu_isa_pkg::csr_addr_t ca);
    case (ca)
      `EXU_CSR_MSTATUS: return m_mstatus;
      `EXU_CSR_MTVEC: return m_mtvec;
      `EXU_CSR_MEPC: return m_mepc;
      `EXU_CSR_MCAUSE: return m_mcause;
      default: return '0;
    endcase
  endfunction

  function automatic exu_isa_pkg::csr_addr_t csr_pick(input int i);
    case (i)
      0: return `EXU_CSR_MSTATUS;
      1: return `EXU_CSR_MTVEC;
      2: return `EXU_CSR_MEPC;
      default: return `EXU_CSR_MCAUSE;
    endcase
  endfunction

  // expected result and model update, in program order
  task automatic predict(input exu_isa_pkg::op_class_t cls, input exu_isa_pkg::alu_op_t op,
                         input exu_isa_pkg::csr_func_t fn,
                         input exu_isa_pkg::word_t s1, s2, base, imm, pc,
                         input exu_isa_pkg::reg_idx_t rd);
    exp_t e;
    exu_isa_pkg::word_t res;
    exu_isa_pkg::word_t old;
    exu_isa_pkg::word_t nv;
    exu_bus_pkg::wb_addr_t a;
    logic old7;
    res = alu_model(op, s1, s2);
    a = exu_bus_pkg::wb_addr_t'((base + imm) >> 2);
    old = csr_read(imm[11:0]);
    e.rd = rd;
    e.pc = pc;
    e.npc = base + imm;
    e.redirect = 1'b0;
    e.wdata = res;
    if (cls == exu_isa_pkg::OP_LOAD) e.wdata = mem_model[a];
    if (cls == exu_isa_pkg::OP_CSR) e.wdata = old;
    if (rd == '0) e.wdata = '0;
    case (cls)
      exu_isa_pkg::OP_JUMP: e.redirect = 1'b1;
      exu_isa_pkg::OP_ECALL: begin
        e.redirect = 1'b1;
        e.npc = m_mtvec;
        m_mepc = pc;
        m_mcause = 32'd11;
      end
      exu_isa_pkg::OP_MRET: begin
        e.redirect = 1'b1;
        e.npc = m_mepc;
        old7 = m_mstatus[7];
        m_mstatus[7] = 1'b1;
        m_mstatus[3] = old7;
      end
      exu_isa_pkg::OP_BRANCH: begin
        if (op == exu_isa_pkg::ALU_SUB) begin
          e.redirect = (res == '0);
        end else if (op inside {exu_isa_pkg::ALU_XOR, exu_isa_pkg::ALU_SLT,
                                exu_isa_pkg::ALU_SLTU, exu_isa_pkg::ALU_SLE,
                                exu_isa_pkg::ALU_SLEU}) begin
          e.redirect = (res != '0);
        end
      end
      exu_isa_pkg::OP_STORE: mem_model[a] = s2;
      exu_isa_pkg::OP_CSR: begin
        nv = (fn == exu_isa_pkg::CSR_WRITE) ? s1 :
             (fn == exu_isa_pkg::CSR_SET) ? (old | s1) : (old & ~s1);
        case (imm[11:0])
          `EXU_CSR_MSTATUS: m_mstatus = nv;
          `EXU_CSR_MTVEC: m_mtvec = nv;
          `EXU_CSR_MEPC: m_mepc = nv;
          `EXU_CSR_MCAUSE: m_mcause = nv;
          default: ;
        endcase
      end
      default: ;
    endcase
    exp_q.push_back(e);
  endtask

  // called 2 ns after a rising edge, returns the same way
  task automatic issue(input exu_isa_pkg::op_class_t cls, input exu_isa_pkg::alu_op_t op,
                       input exu_isa_pkg::csr_func_t fn,
                       input exu_isa_pkg::word_t s1, s2, base, imm, pc,
                       input exu_isa_pkg::reg_idx_t rd);
    int n;
    logic taken;
    predict(cls, op, fn, s1, s2, base, imm, pc, rd);
    op_class_i = cls;
    alu_op_i = op;
    csr_func_i = fn;
    src1_i = s1;
    src2_i = s2;
    base_i = base;
    imm_i = imm;
    pc_i = pc;
    rd_i = rd;
    prev_valid_i = 1'b1;
    n = 0;
    taken = 1'b0;
    while (!taken && n < 50) begin
      @(negedge clk);
      taken = ready_o;
      @(posedge clk);
      #2;
      n++;
    end
    prev_valid_i = 1'b0;
    if (!taken) timeout_abort("ready_o stayed low for 50 cycles");
  endtask

  task automatic mem_op(input logic store, input exu_bus_pkg::wb_addr_t a,
                        input exu_isa_pkg::word_t data, input exu_isa_pkg::reg_idx_t rd);
    exu_isa_pkg::word_t imm;
    exu_isa_pkg::word_t base;
    imm = $urandom();
    base = {22'd0, a, 2'b00} - imm;
    issue(store ? exu_isa_pkg::OP_STORE : exu_isa_pkg::OP_LOAD, exu_isa_pkg::ALU_ADD,
          exu_isa_pkg::CSR_WRITE, $urandom(), data, base, imm, $urandom(), rd);
  endtask

  task automatic csr_op(input exu_isa_pkg::csr_func_t fn, input exu_isa_pkg::csr_addr_t ca,
                        input exu_isa_pkg::word_t s1, input exu_isa_pkg::reg_idx_t rd);
    issue(exu_isa_pkg::OP_CSR, exu_isa_pkg::ALU_ADD, fn, s1, $urandom(), $urandom(),
          {20'($urandom()), ca}, $urandom(), rd);
  endtask

  task automatic finish_test(input string name, input int err0, input int res0);
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() > 0) timeout_abort({"results of test ", name, " did not all arrive"});
    tests_run++;
    if (errors != err0) tests_failed++;
    $display("test %s: %0d results, %0d errors", name, results - res0, errors - err0);
    @(posedge clk);
    #2;
  endtask

  task automatic test_alu();
    int e0;
    int r0;
    exu_isa_pkg::reg_idx_t rd;
    e0 = errors;
    r0 = results;
    for (int op = 0; op < 12; op++) begin
      for (int k = 0; k < 4; k++) begin
        rd = (k == 0) ? 4'd0 : 4'($urandom % 15 + 1);
        issue(exu_isa_pkg::OP_ALU, 4'(op), exu_isa_pkg::CSR_WRITE, $urandom(), $urandom(),
              $urandom(), $urandom(), $urandom(), rd);
      end
    end
    finish_test("alu", e0, r0);
  endtask

  task automatic test_branch();
    int e0;
    int r0;
    exu_isa_pkg::alu_op_t op;
    exu_isa_pkg::word_t a;
    exu_isa_pkg::word_t b;
    exu_isa_pkg::word_t pc;
    e0 = errors;
    r0 = results;
    for (int i = 0; i < 4; i++) begin
      op = (i == 0) ? exu_isa_pkg::ALU_SUB : (i == 1) ? exu_isa_pkg::ALU_XOR :
           (i == 2) ? exu_isa_pkg::ALU_SLT : exu_isa_pkg::ALU_SLTU;
      a = $urandom();
      b = $urandom();
      if (b == a) b = ~a;
      issue(exu_isa_pkg::OP_BRANCH, op, exu_isa_pkg::CSR_WRITE, a, a,
            $urandom(), $urandom(), $urandom(), 4'd0);
      issue(exu_isa_pkg::OP_BRANCH, op, exu_isa_pkg::CSR_WRITE, a, b,
            $urandom(), $urandom(), $urandom(), 4'd0);
      issue(exu_isa_pkg::OP_BRANCH, op, exu_isa_pkg::CSR_WRITE, b, a,
            $urandom(), $urandom(), $urandom(), 4'd0);
    end
    // decoder hands pc and 4 to the adder for the link value
    for (int k = 0; k < 4; k++) begin
      pc = $urandom() & ~32'h3;
      issue(exu_isa_pkg::OP_JUMP, exu_isa_pkg::ALU_ADD, exu_isa_pkg::CSR_WRITE, pc, 32'd4,
            $urandom(), $urandom(), pc, 4'(k + 1));
    end
    finish_test("branch", e0, r0);
  endtask

  task automatic test_mem();
    int e0;
    int r0;
    exu_bus_pkg::wb_addr_t a;
    e0 = errors;
    r0 = results;
    for (int k = 0; k < 10; k++) begin
      a = 8'($urandom);
      written_q.push_back(a);
      mem_op(1'b1, a, $urandom(), 4'd0);
    end
    for (int k = 0; k < 10; k++) begin
      mem_op(1'b0, written_q[written_q.size() - 1 - k], '0, 4'(k % 15 + 1));
    end
    finish_test("load_store", e0, r0);
  endtask

  task automatic test_csr();
    int e0;
    int r0;
    exu_isa_pkg::csr_addr_t ca;
    e0 = errors;
    r0 = results;
    for (int i = 0; i < 4; i++) begin
      ca = csr_pick(i);
      csr_op(exu_isa_pkg::CSR_WRITE, ca, $urandom(), 4'd1);
      csr_op(exu_isa_pkg::CSR_SET, ca, $urandom(), 4'd2);
      csr_op(exu_isa_pkg::CSR_CLEAR, ca, $urandom(), 4'd3);
      csr_op(exu_isa_pkg::CSR_SET, ca, '0, 4'd4);
    end
    finish_test("csr", e0, r0);
  endtask

  task automatic test_trap();
    int e0;
    int r0;
    e0 = errors;
    r0 = results;
    csr_op(exu_isa_pkg::CSR_WRITE, `EXU_CSR_MTVEC, $urandom() & ~32'h3, 4'd5);
    issue(exu_isa_pkg::OP_ECALL, exu_isa_pkg::ALU_ADD, exu_isa_pkg::CSR_WRITE, '0, '0,
          $urandom(), $urandom(), $urandom() & ~32'h3, 4'd0);
    csr_op(exu_isa_pkg::CSR_SET, `EXU_CSR_MEPC, '0, 4'd6);
    csr_op(exu_isa_pkg::CSR_SET, `EXU_CSR_MCAUSE, '0, 4'd7);
    issue(exu_isa_pkg::OP_MRET, exu_isa_pkg::ALU_ADD, exu_isa_pkg::CSR_WRITE, '0, '0,
          $urandom(), $urandom(), $urandom() & ~32'h3, 4'd0);
    csr_op(exu_isa_pkg::CSR_SET, `EXU_CSR_MSTATUS, '0, 4'd8);
    finish_test("ecall_mret", e0, r0);
  endtask

  task automatic test_backpressure();
    int e0;
    int r0;
    int kind;
    exu_bus_pkg::wb_addr_t a;
    e0 = errors;
    r0 = results;
    stall_en = 1'b1;
    for (int k = 0; k < 40; k++) begin
      kind = int'($urandom % 6);
      case (kind)
        0: issue(exu_isa_pkg::OP_ALU, 4'($urandom % 12), exu_isa_pkg::CSR_WRITE, $urandom(),
                 $urandom(), $urandom(), $urandom(), $urandom(), 4'($urandom));
        1: issue(exu_isa_pkg::OP_BRANCH, 4'($urandom % 12), exu_isa_pkg::CSR_WRITE,
                 $urandom(), $urandom(), $urandom(), $urandom(), $urandom(), 4'd0);
        2: begin
          a = 8'($urandom);
          written_q.push_back(a);
          mem_op(1'b1, a, $urandom(), 4'd0);
        end
        3: mem_op(1'b0, written_q[$urandom % written_q.size()], '0, 4'($urandom));
        4: csr_op(2'($urandom % 3), csr_pick(int'($urandom % 4)), $urandom(), 4'($urandom));
        default: issue(($urandom % 2) ? exu_isa_pkg::OP_ECALL : exu_isa_pkg::OP_MRET,
                       exu_isa_pkg::ALU_ADD, exu_isa_pkg::CSR_WRITE, '0, '0,
                       $urandom(), $urandom(), $urandom(), 4'd0);
      endcase
    end
    stall_en = 1'b0;
    finish_test("backpressure", e0, r0);
  endtask

  initial begin
    void'($urandom(32'hb6d3));
    clk = 1'b0;
    rst = 1'b1;
    prev_valid_i = 1'b0;
    op_class_i = exu_isa_pkg::OP_ALU;
    alu_op_i = exu_isa_pkg::ALU_ADD;
    csr_func_i = exu_isa_pkg::CSR_WRITE;
    src1_i = '0;
    src2_i = '0;
    base_i = '0;
    imm_i = '0;
    pc_i = '0;
    rd_i = '0;
    next_ready_i = 1'b1;
    head_valid = 1'b0;
    stall_en = 1'b0;
    stretch = 0;
    errors = 0;
    results = 0;
    tests_run = 0;
    tests_failed = 0;
    m_mstatus = '0;
    m_mtvec = '0;
    m_mepc = '0;
    m_mcause = '0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    test_alu();
    test_branch();
    test_mem();
    test_csr();
    test_trap();
    test_backpressure();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: exu_subsys.f
+incdir+rtl
rtl/exu_isa_pkg.sv
rtl/exu_bus_pkg.sv
rtl/exu_alu.sv
rtl/exu_csr.sv
rtl/exu_lsu_wb.sv
rtl/exu_stage.sv
rtl/data_ram_wb.sv
rtl/exu_subsys_top.sv
testbench/exu_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS = --timing --assert
TOP = exu_tb
FILELIST = exu_subsys.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_MSG = PASS: all tests
FAIL_MSG = FAIL: see errors above

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
